/* common/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Datapath and address width
`define XLEN 32

// Register index width and count
`define REG_ADDR_W 5
`define NUM_REGS 32

// Bubble word is addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* common/decode_pkg.sv */
package decode_pkg;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opBranch = 7'b1100011,
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opImm    = 7'b0010011,
    opReg    = 7'b0110011
  } opcodeE;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB // Operand B straight through for lui
  } aluOpE;

  // Hint from the main decoder to the ALU decoder
  typedef enum logic [1:0] {
    classAdd,
    classReg,
    classImm,
    classBranch
  } aluClassE;

  typedef enum logic [2:0] {
    immI,
    immS,
    immB,
    immU,
    immJ
  } immSrcE;

  typedef enum logic [3:0] {
    brNone,
    brJal,
    brJalr,
    brEq,
    brNe,
    brLt,
    brGe,
    brLtu,
    brGeu
  } branchE;

  typedef enum logic [1:0] {
    memByte,
    memHalf,
    memWord
  } memSizeE;

  typedef enum logic [1:0] {
    resAlu,
    resMem,
    resPcPlus4
  } resultSrcE;

endpackage

/* decoder/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder
  import decode_pkg::*;
(
  input  aluClassE   aluClass,
  input  logic       isLui,
  input  logic [2:0] funct3,
  input  logic       funct7b5,
  output aluOpE      aluControl
);

  logic  subSel; // sub exists only for register ops
  logic  sraSel;
  aluOpE funct3Op;

  assign subSel = funct7b5 && (aluClass == classReg);
  assign sraSel = funct7b5;

  // funct3 map shared by register and immediate ops
  always_comb begin
    case (funct3)
      3'b000:  funct3Op = subSel ? aluSub : aluAdd;
      3'b001:  funct3Op = aluSll;
      3'b010:  funct3Op = aluSlt;
      3'b011:  funct3Op = aluSltu;
      3'b100:  funct3Op = aluXor;
      3'b101:  funct3Op = sraSel ? aluSra : aluSrl;
      3'b110:  funct3Op = aluOr;
      default: funct3Op = aluAnd;
    endcase
  end

  always_comb begin
    case (aluClass)
      classAdd:    aluControl = isLui ? aluPassB : aluAdd;
      classBranch: aluControl = aluSub; // Compare by subtraction
      default:     aluControl = funct3Op;
    endcase
  end

endmodule

/* decoder/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder
  import decode_pkg::*;
(
  input  logic [6:0] opcode,
  input  logic [2:0] funct3,
  output logic       regWrite,
  output logic       memWrite,
  output logic       aluSrcA,   // 1 selects the PC
  output logic       aluSrcB,   // 1 selects the immediate
  output aluClassE   aluClass,
  output immSrcE     immSrc,
  output branchE     branch,
  output memSizeE    memSize,
  output logic       memSigned,
  output resultSrcE  resultSrc,
  output logic       illegal
);

  always_comb begin
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    aluSrcA   = 1'b0;
    aluSrcB   = 1'b1; // Immediate unless reg op or branch
    aluClass  = classAdd;
    immSrc    = immI;
    branch    = brNone;
    memSize   = memWord;
    memSigned = 1'b0;
    resultSrc = resAlu;
    illegal   = 1'b0;

    case (opcodeE'(opcode))
      opLui: begin
        regWrite = 1'b1;
        immSrc   = immU; // ALU decoder turns this into aluPassB
      end
      opAuipc: begin
        regWrite = 1'b1;
        aluSrcA  = 1'b1;
        immSrc   = immU;
      end
      opJal: begin
        regWrite  = 1'b1;
        immSrc    = immJ;
        branch    = brJal;
        resultSrc = resPcPlus4;
      end
      opJalr: begin
        regWrite  = 1'b1;
        branch    = brJalr;
        resultSrc = resPcPlus4;
      end
      opBranch: begin
        aluSrcB  = 1'b0;
        aluClass = classBranch;
        immSrc   = immB;
        case (funct3)
          3'b000:  branch = brEq;
          3'b001:  branch = brNe;
          3'b100:  branch = brLt;
          3'b101:  branch = brGe;
          3'b110:  branch = brLtu;
          3'b111:  branch = brGeu;
          default: illegal = 1'b1;
        endcase
      end
      opLoad: begin
        regWrite  = 1'b1;
        resultSrc = resMem;
        memSigned = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: memSize = memByte;
          3'b001, 3'b101: memSize = memHalf;
          3'b010:         memSize = memWord;
          default:        illegal = 1'b1;
        endcase
      end
      opStore: begin
        memWrite = 1'b1;
        immSrc   = immS;
        case (funct3)
          3'b000:  memSize = memByte;
          3'b001:  memSize = memHalf;
          3'b010:  memSize = memWord;
          default: illegal = 1'b1;
        endcase
      end
      opImm: begin
        regWrite = 1'b1;
        aluClass = classImm;
      end
      opReg: begin
        regWrite = 1'b1;
        aluSrcB  = 1'b0;
        aluClass = classReg;
      end
      default: illegal = 1'b1;
    endcase

    // Illegal words leave the pipe as a bubble
    if (illegal) begin
      regWrite  = 1'b0;
      memWrite  = 1'b0;
      branch    = brNone;
      resultSrc = resAlu;
    end
  end

endmodule

/* design/decodeStage.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module decodeStage
  import decode_pkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`XLEN-1:0]       instrF,
  input  logic [`XLEN-1:0]       pcF,
  input  logic [`XLEN-1:0]       pcPlus4F,
  input  logic                   stallD,
  input  logic                   flushD,
  input  logic                   regWriteW,
  input  logic [`REG_ADDR_W-1:0] rdW,
  input  logic [`XLEN-1:0]       resultW,
  output logic [`XLEN-1:0]       rd1D,
  output logic [`XLEN-1:0]       rd2D,
  output logic [`XLEN-1:0]       immExtD,
  output logic [`REG_ADDR_W-1:0] rs1D,
  output logic [`REG_ADDR_W-1:0] rs2D,
  output logic [`REG_ADDR_W-1:0] rdD,
  output logic [`XLEN-1:0]       pcD,
  output logic [`XLEN-1:0]       pcPlus4D,
  output logic                   regWriteD,
  output logic                   memWriteD,
  output logic                   aluSrcAD,
  output logic                   aluSrcBD,
  output aluOpE                  aluControlD,
  output branchE                 branchD,
  output memSizeE                memSizeD,
  output logic                   memSignedD,
  output resultSrcE              resultSrcD,
  output logic                   illegalD
);

  logic [`XLEN-1:0]       instrD;
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic                   funct7b5;
  logic [`REG_ADDR_W-1:0] rdField;
  logic                   isLui;
  logic                   regWriteDec;
  aluClassE               aluClass;
  immSrcE                 immSrc;

  // IF/ID register where flush wins over stall
  always_ff @(posedge clk) begin
    if (!rstN || flushD) begin
      instrD   <= `NOP_INSTR;
      pcD      <= '0;
      pcPlus4D <= '0;
    end else if (!stallD) begin
      instrD   <= instrF;
      pcD      <= pcF;
      pcPlus4D <= pcPlus4F;
    end
  end

  assign opcode   = instrD[6:0];
  assign funct3   = instrD[14:12];
  assign funct7b5 = instrD[30];
  assign rdField  = instrD[11:7];
  assign rs1D     = instrD[19:15];
  assign rs2D     = instrD[24:20];
  assign isLui    = (opcode == opLui);

  // Writes to x0 are dropped here so the bubble carries no write
  assign regWriteD = regWriteDec && (rdField != '0);
  assign rdD       = regWriteD ? rdField : '0;

  mainDecoder u_mainDec (
    .opcode    (opcode),
    .funct3    (funct3),
    .regWrite  (regWriteDec),
    .memWrite  (memWriteD),
    .aluSrcA   (aluSrcAD),
    .aluSrcB   (aluSrcBD),
    .aluClass  (aluClass),
    .immSrc    (immSrc),
    .branch    (branchD),
    .memSize   (memSizeD),
    .memSigned (memSignedD),
    .resultSrc (resultSrcD),
    .illegal   (illegalD)
  );

  aluDecoder u_aluDec (
    .aluClass   (aluClass),
    .isLui      (isLui),
    .funct3     (funct3),
    .funct7b5   (funct7b5),
    .aluControl (aluControlD)
  );

  immExtend u_immExt (
    .instrHi (instrD[31:7]),
    .immSrc  (immSrc),
    .immExt  (immExtD)
  );

  regFile u_regFile (
    .clk  (clk),
    .rstN (rstN),
    .ra1  (rs1D),
    .ra2  (rs2D),
    .we   (regWriteW),
    .wa   (rdW),
    .wd   (resultW),
    .rd1  (rd1D),
    .rd2  (rd2D)
  );

endmodule

/* design/immExtend.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module immExtend
  import decode_pkg::*;
(
  input  logic [24:0]      instrHi, // Instruction bits 31 to 7
  input  immSrcE           immSrc,
  output logic [`XLEN-1:0] immExt
);

  logic [31:0] ins;

  // Realign so the fields keep their instruction bit numbers
  assign ins = {instrHi, 7'b0};

  always_comb begin
    case (immSrc)
      immS: immExt = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB: begin
        immExt = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      immU: immExt = {ins[31:12], 12'b0};
      immJ: begin
        immExt = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: immExt = {{20{ins[31]}}, ins[31:20]}; // I format
    endcase
  end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module regFile (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`REG_ADDR_W-1:0] ra1,
  input  logic [`REG_ADDR_W-1:0] ra2,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] wa,
  input  logic [`XLEN-1:0]       wd,
  output logic [`XLEN-1:0]       rd1,
  output logic [`XLEN-1:0]       rd2
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             hit1;
  logic             hit2;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd; // x0 never written
    end
  end

  // Same-cycle writeback seen by the reader
  assign hit1 = we && (wa == ra1);
  assign hit2 = we && (wa == ra2);

  assign rd1 = (ra1 == '0) ? '0 : (hit1 ? wd : regs[ra1]);
  assign rd2 = (ra2 == '0) ? '0 : (hit2 ? wd : regs[ra2]);

endmodule

/* dv/decode_assert.sv */
`timescale 1ns/1ps

module decode_assert
  import decode_pkg::*;
(
  input logic      clk,
  input logic      rstN,
  input logic      regWriteD,
  input logic      memWriteD,
  input logic      illegalD,
  input branchE    branchD,
  input resultSrcE resultSrcD
);

  logic quiet; // No write, branch or fault leaves the stage

  assign quiet = !regWriteD && !memWriteD && !illegalD
                 && branchD == brNone && resultSrcD == resAlu;

  // Reset loads the bubble that holds until one cycle after release
  aResetQuiet: assert property (@(posedge clk) !rstN |=> quiet)
    else $error("decode controls active during or right after reset");

  aOneWrite: assert property (@(posedge clk) disable iff (!rstN) !(regWriteD && memWriteD))
    else $error("regWriteD and memWriteD both high");

  aIllegalBubble: assert property (@(posedge clk) disable iff (!rstN)
    illegalD |-> !regWriteD && !memWriteD && branchD == brNone)
    else $error("illegal instruction left active controls");

endmodule

bind decodeStage decode_assert u_assert (.*);

/* dv/decode_tb.sv */
`timescale 1ns/1ps
`include "decode_defs.svh"

module decode_tb
  import decode_pkg::*;
();

  localparam int NumCtl   = 2000;
  localparam int NumImm   = 400;
  localparam int NumRf    = 400;
  localparam int NumStall = 200;
  localparam int NumIll   = 300;
  // Reset, register sweep, every test and a margin
  localparam int TotalCycles = 16 + 33 + NumCtl + NumImm + NumRf + NumStall + NumIll + 100;

  logic                   clk = 1'b0;
  logic                   rstN, stallD, flushD, regWriteW;
  logic [`XLEN-1:0]       instrF, pcF, pcPlus4F, resultW;
  logic [`REG_ADDR_W-1:0] rdW, rs1D, rs2D, rdD;
  logic [`XLEN-1:0]       rd1D, rd2D, immExtD, pcD, pcPlus4D;
  logic                   regWriteD, memWriteD, aluSrcAD, aluSrcBD, memSignedD, illegalD;
  aluOpE                  aluControlD;
  branchE                 branchD;
  memSizeE                memSizeD;
  resultSrcE              resultSrcD;

  logic [`XLEN-1:0] shadow [`NUM_REGS]; // Model register file
  logic [`XLEN-1:0] ifidWord, ifidPc, ifidPc4; // Model IF/ID register
  logic [31:0]      rngState;
  string            curTest;
  int               testChecks, testErrors, totalChecks, totalErrors, numTests;
  opcodeE           legalOps [9] = '{opLui, opAuipc, opJal, opJalr, opBranch, opLoad,
                                     opStore, opImm, opReg};

  decodeStage u_dut (.*);

  always #2 clk = ~clk; // 4 ns period

  function automatic logic [31:0] xorshift();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function automatic logic legal(input logic [31:0] w);
    case (w[6:0])
      opBranch: return !(w[14:12] inside {3'd2, 3'd3});
      opLoad:   return w[14:12] inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      opStore:  return w[14:12] < 3'd3;
      opLui, opAuipc, opJal, opJalr, opImm, opReg: return 1'b1;
      default:  return 1'b0;
    endcase
  endfunction

  function automatic branchE branchFor(input logic [31:0] w);
    if (w[6:0] == opJal) return brJal;
    if (w[6:0] == opJalr) return brJalr;
    if (w[6:0] != opBranch) return brNone;
    case (w[14:12])
      3'd0:    return brEq;
      3'd1:    return brNe;
      3'd4:    return brLt;
      3'd5:    return brGe;
      3'd6:    return brLtu;
      default: return brGeu;
    endcase
  endfunction

  function automatic resultSrcE resultFor(input logic [31:0] w);
    if (w[6:0] == opLoad) return resMem;
    if (w[6:0] inside {opJal, opJalr}) return resPcPlus4;
    return resAlu;
  endfunction

  function automatic aluOpE aluFor(input logic [31:0] w);
    if (w[6:0] == opLui) return aluPassB;
    if (w[6:0] == opBranch) return aluSub;
    if (!(w[6:0] inside {opReg, opImm})) return aluAdd; // Address and link adds
    case (w[14:12])
      3'd0:    return (w[6:0] == opReg && w[30]) ? aluSub : aluAdd;
      3'd1:    return aluSll;
      3'd2:    return aluSlt;
      3'd3:    return aluSltu;
      3'd4:    return aluXor;
      3'd5:    return w[30] ? aluSra : aluSrl;
      3'd6:    return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  function automatic logic [31:0] immFor(input logic [31:0] w);
    case (w[6:0])
      opLui, opAuipc: return {w[31:12], 12'b0};
      opJal:          return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      opBranch:       return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      opStore:        return {{21{w[31]}}, w[30:25], w[11:7]};
      default:        return {{21{w[31]}}, w[30:20]};
    endcase
  endfunction

  function automatic logic [31:0] readModel(input logic [4:0] a);
    if (a == 5'd0) return '0;
    return (regWriteW && rdW == a) ? resultW : shadow[a];
  endfunction

  function automatic logic [31:0] randLegal(input logic noReg);
    logic [31:0] w;
    do begin
      w = xorshift();
      w[6:0] = legalOps[xorshift() % 9];
      if (w[6:0] == opJalr) w[14:12] = 3'd0;
      if (w[6:0] == opReg || (w[6:0] == opImm && w[13:12] == 2'b01)) begin
        w[31] = 1'b0; // funct7 is 0 or 0100000
        w[29:25] = 5'd0;
        if (!(w[14:12] inside {3'd0, 3'd5}) || w[6:0] == opImm && !w[14]) w[30] = 1'b0;
      end
    end while (!legal(w) || (noReg && w[6:0] == opReg));
    return w;
  endfunction

  function automatic logic [31:0] randIllegal();
    logic [31:0] w;
    do begin
      w = xorshift();
      case (w[9:8]) // Bias toward bad funct3 on known opcodes
        2'd1:    w[6:0] = opBranch;
        2'd2:    w[6:0] = opLoad;
        2'd3:    w[6:0] = opStore;
        default: ;
      endcase
    end while (legal(w));
    return w;
  endfunction

  task automatic tally(input string field, input logic ok, input string expS, actS);
    testChecks++;
    if (ok !== 1'b1) begin
      testErrors++;
      $display("** Error %s %s: expected %s, actual %s", curTest, field, expS, actS);
    end
  endtask

  task automatic checkWord(input string field, input logic [31:0] exp, act);
    tally(field, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic checkBit(input string field, input logic exp, act);
    tally(field, exp === act, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic checkAluOp(input string field, input aluOpE exp, act);
    tally(field, exp === act, exp.name(), act.name());
  endtask

  task automatic checkBranch(input string field, input branchE exp, act);
    tally(field, exp === act, exp.name(), act.name());
  endtask

  task automatic checkMemSize(input string field, input memSizeE exp, act);
    tally(field, exp === act, exp.name(), act.name());
  endtask

  task automatic checkResultSrc(input string field, input resultSrcE exp, act);
    tally(field, exp === act, exp.name(), act.name());
  endtask

  // Compares every output with the model of the current IF/ID contents
  task automatic checkState();
    logic [6:0] op;
    logic [2:0] f3;
    logic       ok;
    logic       wr;
    op = ifidWord[6:0];
    f3 = ifidWord[14:12];
    ok = legal(ifidWord);
    wr = ok && (op inside {opLui, opAuipc, opJal, opJalr, opLoad, opImm, opReg})
         && ifidWord[11:7] != 5'd0;
    checkWord("pcD", ifidPc, pcD);
    checkWord("pcPlus4D", ifidPc4, pcPlus4D);
    checkWord("rs1D", ifidWord[19:15], rs1D);
    checkWord("rs2D", ifidWord[24:20], rs2D);
    checkWord("rdD", wr ? ifidWord[11:7] : 5'd0, rdD);
    checkWord("rd1D", readModel(ifidWord[19:15]), rd1D);
    checkWord("rd2D", readModel(ifidWord[24:20]), rd2D);
    checkBit("illegalD", !ok, illegalD);
    checkBit("regWriteD", wr, regWriteD);
    checkBit("memWriteD", ok && op == opStore, memWriteD);
    checkBranch("branchD", ok ? branchFor(ifidWord) : brNone, branchD);
    checkResultSrc("resultSrcD", ok ? resultFor(ifidWord) : resAlu, resultSrcD);
    if (ok) begin
      checkBit("aluSrcAD", op == opAuipc, aluSrcAD);
      checkBit("aluSrcBD", !(op inside {opReg, opBranch}), aluSrcBD);
      checkAluOp("aluControlD", aluFor(ifidWord), aluControlD);
      if (op != opReg) checkWord("immExtD", immFor(ifidWord), immExtD);
      if (op inside {opLoad, opStore}) checkMemSize("memSizeD", memSizeE'(f3[1:0]), memSizeD);
      if (op == opLoad) checkBit("memSignedD", !(f3 inside {3'd4, 3'd5}), memSignedD);
    end
  endtask

  // Called on a falling edge, returns on the next one
  task automatic runCycle(input logic [31:0] instr, input logic stall, flush, we,
                          input logic [4:0] wa, input logic [31:0] wd);
    instrF    = instr;
    pcF       = xorshift() & 32'hffff_fffc;
    pcPlus4F  = pcF + 32'd4;
    stallD    = stall;
    flushD    = flush;
    regWriteW = we;
    rdW       = wa;
    resultW   = wd;
    #1;
    checkState();
    @(posedge clk);
    if (flush) begin
      ifidWord = `NOP_INSTR;
      ifidPc   = '0;
      ifidPc4  = '0;
    end else if (!stall) begin
      ifidWord = instr;
      ifidPc   = pcF;
      ifidPc4  = pcPlus4F;
    end
    if (we && wa != 5'd0) shadow[wa] = wd;
    @(negedge clk);
  endtask

  task automatic startTest(input string name);
    curTest    = name;
    testChecks = 0;
    testErrors = 0;
  endtask

  task automatic endTest();
    $display("Test %s: %0d checks, %0d errors", curTest, testChecks, testErrors);
    totalChecks += testChecks;
    totalErrors += testErrors;
    numTests++;
  endtask

  initial begin
    logic [31:0] r;
    rngState  = 32'hc761;
    rstN      = 1'b0;
    instrF    = `NOP_INSTR;
    pcF       = '0;
    pcPlus4F  = '0;
    stallD    = 1'b0;
    flushD    = 1'b0;
    regWriteW = 1'b0;
    rdW       = '0;
    resultW   = '0;
    ifidWord  = `NOP_INSTR;
    ifidPc    = '0;
    ifidPc4   = '0;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (16) @(negedge clk);
    rstN = 1'b1;

    startTest("resetState"); // Bubble first and then a sweep over all registers
    for (int i = 0; i < 33; i++)
      runCycle({7'd0, 5'(31 - i), 5'(i), 3'd0, 5'd0, opReg}, 1'b0, 1'b0, 1'b0, 5'd0, '0);
    endTest();

    startTest("controlDecode");
    for (int i = 0; i < NumCtl; i++) runCycle(randLegal(1'b0), 1'b0, 1'b0, 1'b0, 5'd0, '0);
    endTest();

    startTest("immediates");
    for (int i = 0; i < NumImm; i++) runCycle(randLegal(1'b1), 1'b0, 1'b0, 1'b0, 5'd0, '0);
    endTest();

    startTest("registerFile");
    for (int i = 0; i < NumRf; i++) begin
      r = xorshift();
      // Aim half the writes at the register being read right now
      runCycle(randLegal(1'b0), 1'b0, 1'b0, r[0] | r[1],
               (r[3:2] == 2'd0) ? 5'd0 : r[4] ? ifidWord[19:15] : r[9:5], xorshift());
    end
    endTest();

    startTest("stallFlush");
    for (int i = 0; i < NumStall; i++) begin
      r = xorshift();
      runCycle(randLegal(1'b0), r[0], r[3:1] == 3'd0, 1'b0, 5'd0, '0);
    end
    endTest();

    startTest("illegal");
    for (int i = 0; i < NumIll; i++) runCycle(randIllegal(), 1'b0, 1'b0, 1'b0, 5'd0, '0);
    runCycle(`NOP_INSTR, 1'b0, 1'b0, 1'b0, 5'd0, '0);
    endTest();

    $display("Tests %0d, checks %0d, errors %0d", numTests, totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(TotalCycles * 4.0);
    $display("Timeout: the tests did not finish within %0d cycles", TotalCycles);
    $display("Verification failed");
    $finish;
  end

endmodule

/* src.f */
+incdir+common
common/decode_pkg.sv
decoder/mainDecoder.sv
decoder/aluDecoder.sv
design/immExtend.sv
design/regFile.sv
design/decodeStage.sv
dv/decode_assert.sv
dv/decode_tb.sv
